// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] rv_word_t;
    typedef logic [4:0] rv_reg_idx_t;

    // One instruction word seen through each of the base formats
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_instr_u;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } rv_alu_op_e;

    typedef enum logic [1:0] {
        A_SRC_REG  = 2'd0,
        A_SRC_PC   = 2'd1,
        A_SRC_ZERO = 2'd2
    } rv_a_src_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_PC4 = 2'd1
    } rv_res_src_e;

    // Major opcodes handled by this slice
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } rv_opcode_e;

endpackage

`default_nettype wire

// File: logic/rv_id_ex_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rv_id_ex_if;
    import rv_pkg::*;

    logic        valid;
    logic        reg_write;
    rv_a_src_e   alu_a_src;
    // High selects the immediate as operand B
    logic        alu_b_src;
    rv_alu_op_e  alu_op;
    rv_res_src_e res_src;
    logic        is_branch;
    logic        is_jump;
    // High takes rs1 as the jump base (JALR)
    logic        jb_target_src;
    logic [2:0]  funct3;
    rv_reg_idx_t rd;
    rv_word_t    rs1_data;
    rv_word_t    rs2_data;
    rv_word_t    imm;
    rv_word_t    pc;
    rv_word_t    pc_plus4;
    // Branch compare results over bits 15:0
    logic        rs_eq_lo;
    logic        rs_lt_u_lo;
    logic        rs_lt_s_lo;

    modport producer (
        output valid, reg_write, alu_a_src, alu_b_src, alu_op, res_src,
        output is_branch, is_jump, jb_target_src, funct3, rd,
        output rs1_data, rs2_data, imm, pc, pc_plus4,
        output rs_eq_lo, rs_lt_u_lo, rs_lt_s_lo
    );

    modport consumer (
        input valid, reg_write, alu_a_src, alu_b_src, alu_op, res_src,
        input is_branch, is_jump, jb_target_src, funct3, rd,
        input rs1_data, rs2_data, imm, pc, pc_plus4,
        input rs_eq_lo, rs_lt_u_lo, rs_lt_s_lo
    );

endinterface

`default_nettype wire

// File: logic/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic                instr_valid,
    input  rv_pkg::rv_instr_u   instr,
    input  rv_pkg::rv_word_t    pc,
    output rv_pkg::rv_reg_idx_t rs1_idx,
    output rv_pkg::rv_reg_idx_t rs2_idx,
    input  rv_pkg::rv_word_t    rs1_data,
    input  rv_pkg::rv_word_t    rs2_data,
    rv_id_ex_if.producer        id
);
    import rv_pkg::*;

    rv_word_t imm_i;
    rv_word_t imm_b;
    rv_word_t imm_u;
    rv_word_t imm_j;
    logic     op_ok;
    logic     alt;

    // funct3 to ALU operation, alt picks SUB or SRA
    function automatic rv_alu_op_e f3_to_alu(input logic [2:0] f3, input logic sub_sra);
        rv_alu_op_e op;
        case (f3)
            3'b000:  op = sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign rs1_idx = instr.r.rs1;
    assign rs2_idx = instr.r.rs2;

    // Sign-extended immediates, one per format
    assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'b0};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    assign alt = instr.r.funct7[5];

    always_comb begin
        op_ok            = 1'b1;
        id.reg_write     = 1'b0;
        id.alu_a_src     = A_SRC_ZERO;
        id.alu_b_src     = 1'b1;
        id.alu_op        = ALU_PASS_B;
        id.res_src       = RES_ALU;
        id.is_branch     = 1'b0;
        id.is_jump       = 1'b0;
        id.jb_target_src = 1'b0;
        id.imm           = imm_i;

        case (instr.r.opcode)
            // Zero plus the U immediate through the pass-b default
            OP_LUI: begin
                id.reg_write = 1'b1;
                id.imm       = imm_u;
            end
            OP_AUIPC: begin
                id.reg_write = 1'b1;
                id.alu_a_src = A_SRC_PC;
                id.alu_op    = ALU_ADD;
                id.imm       = imm_u;
            end
            OP_JAL: begin
                id.reg_write = 1'b1;
                id.res_src   = RES_PC4;
                id.is_jump   = 1'b1;
                id.imm       = imm_j;
            end
            OP_JALR: begin
                id.reg_write     = 1'b1;
                id.res_src       = RES_PC4;
                id.is_jump       = 1'b1;
                id.jb_target_src = 1'b1;
                op_ok            = (instr.i.funct3 == 3'b000);
            end
            OP_BRANCH: begin
                id.is_branch = 1'b1;
                id.imm       = imm_b;
                // funct3 010 and 011 are not branches
                op_ok        = (instr.b.funct3[2:1] != 2'b01);
            end
            OP_IMM: begin
                id.reg_write = 1'b1;
                id.alu_a_src = A_SRC_REG;
                // Only SRAI has an alternate form among the immediates
                id.alu_op    = f3_to_alu(instr.i.funct3, alt && instr.i.funct3 == 3'b101);
            end
            OP_REG: begin
                id.reg_write = 1'b1;
                id.alu_a_src = A_SRC_REG;
                id.alu_b_src = 1'b0;
                id.alu_op    = f3_to_alu(instr.r.funct3, alt);
            end
            default: begin
                op_ok = 1'b0;
            end
        endcase
    end

    assign id.valid    = instr_valid && op_ok;
    assign id.funct3   = instr.r.funct3;
    assign id.rd       = instr.r.rd;
    assign id.rs1_data = rs1_data;
    assign id.rs2_data = rs2_data;
    assign id.pc       = pc;
    assign id.pc_plus4 = pc + 32'd4;

    // First half of the branch compare, finished in execute
    assign id.rs_eq_lo   = (rs1_data[15:0] == rs2_data[15:0]);
    assign id.rs_lt_u_lo = (rs1_data[15:0] < rs2_data[15:0]);
    // Below the sign bit the low half orders as unsigned for both flavours
    assign id.rs_lt_s_lo = $signed({1'b0, rs1_data[15:0]}) < $signed({1'b0, rs2_data[15:0]});

endmodule

`default_nettype wire

// File: logic/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile #(
    parameter bit WRITE_THROUGH = 1'b1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_pkg::rv_reg_idx_t rs1_idx,
    input  rv_pkg::rv_reg_idx_t rs2_idx,
    output rv_pkg::rv_word_t    rs1_data,
    output rv_pkg::rv_word_t    rs2_data,
    input  logic                we,
    input  rv_pkg::rv_reg_idx_t rd,
    input  rv_pkg::rv_word_t    wdata
);
    import rv_pkg::*;

    // x0 has no storage
    rv_word_t regs [31:1];
    logic     fwd1;
    logic     fwd2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Same-cycle write shows up on the read port
    assign fwd1 = WRITE_THROUGH && we && (rd == rs1_idx);
    assign fwd2 = WRITE_THROUGH && we && (rd == rs2_idx);

    assign rs1_data = (rs1_idx == '0) ? '0 : fwd1 ? wdata : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : fwd2 ? wdata : regs[rs2_idx];

endmodule

`default_nettype wire

// File: logic/rv_reg_id_ex.sv
`timescale 1ns/1ps
`default_nettype none

module rv_reg_id_ex #(
    parameter int ID_EX_REG = 1
) (
    input logic          clk,
    input logic          rst_n,
    input logic          flush,
    rv_id_ex_if.consumer id,
    rv_id_ex_if.producer ex
);
    import rv_pkg::*;

    if (ID_EX_REG != 0) begin : g_reg
        // Flush squashes the instruction decoded under a redirect
        always_ff @(posedge clk) begin
            if (!rst_n || flush) begin
                ex.valid         <= 1'b0;
                ex.reg_write     <= 1'b0;
                ex.alu_a_src     <= A_SRC_REG;
                ex.alu_b_src     <= 1'b0;
                ex.alu_op        <= ALU_ADD;
                ex.res_src       <= RES_ALU;
                ex.is_branch     <= 1'b0;
                ex.is_jump       <= 1'b0;
                ex.jb_target_src <= 1'b0;
                ex.funct3        <= '0;
                ex.rd            <= '0;
                ex.rs1_data      <= '0;
                ex.rs2_data      <= '0;
                ex.imm           <= '0;
                ex.pc            <= '0;
                ex.pc_plus4      <= '0;
                ex.rs_eq_lo      <= 1'b0;
                ex.rs_lt_u_lo    <= 1'b0;
                ex.rs_lt_s_lo    <= 1'b0;
            end else begin
                ex.valid         <= id.valid;
                ex.reg_write     <= id.reg_write;
                ex.alu_a_src     <= id.alu_a_src;
                ex.alu_b_src     <= id.alu_b_src;
                ex.alu_op        <= id.alu_op;
                ex.res_src       <= id.res_src;
                ex.is_branch     <= id.is_branch;
                ex.is_jump       <= id.is_jump;
                ex.jb_target_src <= id.jb_target_src;
                ex.funct3        <= id.funct3;
                ex.rd            <= id.rd;
                ex.rs1_data      <= id.rs1_data;
                ex.rs2_data      <= id.rs2_data;
                ex.imm           <= id.imm;
                ex.pc            <= id.pc;
                ex.pc_plus4      <= id.pc_plus4;
                ex.rs_eq_lo      <= id.rs_eq_lo;
                ex.rs_lt_u_lo    <= id.rs_lt_u_lo;
                ex.rs_lt_s_lo    <= id.rs_lt_s_lo;
            end
        end
    end else begin : g_pass
        // Stage collapsed, decode feeds execute in the same cycle
        assign ex.valid         = id.valid;
        assign ex.reg_write     = id.reg_write;
        assign ex.alu_a_src     = id.alu_a_src;
        assign ex.alu_b_src     = id.alu_b_src;
        assign ex.alu_op        = id.alu_op;
        assign ex.res_src       = id.res_src;
        assign ex.is_branch     = id.is_branch;
        assign ex.is_jump       = id.is_jump;
        assign ex.jb_target_src = id.jb_target_src;
        assign ex.funct3        = id.funct3;
        assign ex.rd            = id.rd;
        assign ex.rs1_data      = id.rs1_data;
        assign ex.rs2_data      = id.rs2_data;
        assign ex.imm           = id.imm;
        assign ex.pc            = id.pc;
        assign ex.pc_plus4      = id.pc_plus4;
        assign ex.rs_eq_lo      = id.rs_eq_lo;
        assign ex.rs_lt_u_lo    = id.rs_lt_u_lo;
        assign ex.rs_lt_s_lo    = id.rs_lt_s_lo;
    end

endmodule

`default_nettype wire

// File: logic/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    rv_id_ex_if.consumer        ex,
    output logic                wb_valid,
    output logic                wb_reg_write,
    output rv_pkg::rv_reg_idx_t wb_rd,
    output rv_pkg::rv_word_t    wb_data,
    output logic                redirect,
    output rv_pkg::rv_word_t    redirect_pc
);
    import rv_pkg::*;

    rv_word_t   op_a;
    rv_word_t   op_b;
    rv_word_t   alu_res;
    logic [4:0] shamt;
    logic       hi_eq;
    logic       hi_lt_u;
    logic       hi_lt_s;
    logic       cmp_eq;
    logic       cmp_lt_u;
    logic       cmp_lt_s;
    logic       taken;
    rv_word_t   jb_base;
    rv_word_t   jb_sum;

    always_comb begin
        case (ex.alu_a_src)
            A_SRC_REG: op_a = ex.rs1_data;
            A_SRC_PC:  op_a = ex.pc;
            default:   op_a = '0;
        endcase
    end

    assign op_b  = ex.alu_b_src ? ex.imm : ex.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_b;
        endcase
    end

    // High halves decide unless equal, then the decode-stage result holds
    assign hi_eq   = (ex.rs1_data[31:16] == ex.rs2_data[31:16]);
    assign hi_lt_u = (ex.rs1_data[31:16] < ex.rs2_data[31:16]);
    assign hi_lt_s = $signed(ex.rs1_data[31:16]) < $signed(ex.rs2_data[31:16]);

    assign cmp_eq   = hi_eq && ex.rs_eq_lo;
    assign cmp_lt_u = hi_eq ? ex.rs_lt_u_lo : hi_lt_u;
    assign cmp_lt_s = hi_eq ? ex.rs_lt_s_lo : hi_lt_s;

    always_comb begin
        case (ex.funct3)
            3'b000:  taken = cmp_eq;
            3'b001:  taken = !cmp_eq;
            3'b100:  taken = cmp_lt_s;
            3'b101:  taken = !cmp_lt_s;
            3'b110:  taken = cmp_lt_u;
            3'b111:  taken = !cmp_lt_u;
            default: taken = 1'b0;
        endcase
    end

    // JALR target is rs1 relative with bit 0 dropped
    assign jb_base     = ex.jb_target_src ? ex.rs1_data : ex.pc;
    assign jb_sum      = jb_base + ex.imm;
    assign redirect_pc = {jb_sum[31:1], jb_sum[0] & ~ex.jb_target_src};

    assign redirect = ex.valid && (ex.is_jump || (ex.is_branch && taken));

    assign wb_valid     = ex.valid;
    assign wb_reg_write = ex.valid && ex.reg_write && (ex.rd != '0);
    assign wb_rd        = ex.rd;
    assign wb_data      = (ex.res_src == RES_PC4) ? ex.pc_plus4 : alu_res;

endmodule

`default_nettype wire

// File: logic/rv_core_slice.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_slice #(
    parameter int ID_EX_REG = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  rv_pkg::rv_word_t    instr,
    input  rv_pkg::rv_word_t    pc,
    output logic                wb_valid,
    output logic                wb_reg_write,
    output rv_pkg::rv_reg_idx_t wb_rd,
    output rv_pkg::rv_word_t    wb_data,
    output logic                redirect,
    output rv_pkg::rv_word_t    redirect_pc
);
    import rv_pkg::*;

    rv_reg_idx_t rs1_idx;
    rv_reg_idx_t rs2_idx;
    rv_word_t    rs1_data;
    rv_word_t    rs2_data;

    rv_id_ex_if id_bus ();
    rv_id_ex_if ex_bus ();

    rv_decode u_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .id          (id_bus)
    );

    // Without the ID/EX stage the write belongs to the instruction being read,
    // so write-through would close a combinational loop
    rv_regfile #(
        .WRITE_THROUGH (ID_EX_REG != 0)
    ) u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (wb_reg_write),
        .rd       (wb_rd),
        .wdata    (wb_data)
    );

    rv_reg_id_ex #(
        .ID_EX_REG (ID_EX_REG)
    ) u_reg_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (redirect),
        .id    (id_bus),
        .ex    (ex_bus)
    );

    rv_execute u_execute (
        .ex           (ex_bus),
        .wb_valid     (wb_valid),
        .wb_reg_write (wb_reg_write),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

endmodule

`default_nettype wire

// File: tb/rv_core_slice_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_slice_tb #(
    parameter int ID_EX_REG = 1
);
    import rv_pkg::*;

    // One expected write-back and redirect per executed instruction
    typedef struct packed {
        rv_word_t    pc;
        logic        we;
        rv_reg_idx_t rd;
        rv_word_t    data;
        logic        taken;
        rv_word_t    target;
    } exp_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        instr_valid;
    rv_word_t    instr;
    rv_word_t    pc;
    logic        wb_valid;
    logic        wb_reg_write;
    rv_reg_idx_t wb_rd;
    rv_word_t    wb_data;
    logic        redirect;
    rv_word_t    redirect_pc;

    rv_word_t prog [0:255];
    int       prog_len;
    rv_word_t ref_regs [0:31];
    exp_t     exp_q [$];
    integer   seed;
    int       errors = 0;
    int       checks = 0;
    int       cycle_count = 0;
    int       cycle_limit = 1000;
    logic     quiet;
    logic     fetch_on;
    rv_word_t fetch_pc;
    int       slot;

    always #5 clk = ~clk;

    rv_core_slice #(
        .ID_EX_REG (ID_EX_REG)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .wb_valid     (wb_valid),
        .wb_reg_write (wb_reg_write),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    function automatic rv_word_t enc_r(input logic [6:0] f7, input rv_reg_idx_t rs2,
                                       input rv_reg_idx_t rs1, input logic [2:0] f3,
                                       input rv_reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic rv_word_t enc_i(input logic [11:0] imm, input rv_reg_idx_t rs1,
                                       input logic [2:0] f3, input rv_reg_idx_t rd,
                                       input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_word_t enc_u(input logic [19:0] imm, input rv_reg_idx_t rd,
                                       input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic rv_word_t enc_b(input logic [12:0] off, input rv_reg_idx_t rs2,
                                       input rv_reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic rv_word_t enc_j(input logic [20:0] off, input rv_reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // ISA arithmetic for OP and OP-IMM where alt selects SUB or SRA
    function automatic rv_word_t alu_model(input logic [2:0] f3, input logic alt,
                                           input rv_word_t a, input rv_word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? rv_word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Architectural step on the model register file
    function automatic void rv_ref_step(input rv_word_t ins, input rv_word_t cur_pc,
                                        output rv_reg_idx_t rd, output logic we,
                                        output rv_word_t data, output logic taken,
                                        output rv_word_t target);
        logic [2:0] f3;
        rv_word_t   a;
        rv_word_t   b;
        rv_word_t   imm_i;
        rv_word_t   imm_b;
        rv_word_t   imm_j;
        f3     = ins[14:12];
        rd     = ins[11:7];
        a      = ref_regs[ins[19:15]];
        b      = ref_regs[ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_b  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        we     = 1'b0;
        data   = '0;
        taken  = 1'b0;
        target = '0;
        case (ins[6:0])
            OP_LUI: begin
                we   = 1'b1;
                data = {ins[31:12], 12'b0};
            end
            OP_AUIPC: begin
                we   = 1'b1;
                data = cur_pc + {ins[31:12], 12'b0};
            end
            OP_JAL: begin
                we     = 1'b1;
                data   = cur_pc + 32'd4;
                taken  = 1'b1;
                target = cur_pc + imm_j;
            end
            OP_JALR: begin
                we     = 1'b1;
                data   = cur_pc + 32'd4;
                taken  = 1'b1;
                target = (a + imm_i) & ~32'd1;
            end
            OP_BRANCH: begin
                target = cur_pc + imm_b;
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
            end
            OP_IMM: begin
                we   = 1'b1;
                data = alu_model(f3, ins[30] && f3 == 3'd5, a, imm_i);
            end
            default: begin
                we   = 1'b1;
                data = alu_model(f3, ins[30], a, b);
            end
        endcase
        if (rd == '0) begin
            we = 1'b0;
        end
        if (we) begin
            ref_regs[rd] = data;
        end
    endfunction

    task automatic emit(input rv_word_t word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // LUI then ADDI with the upper part rounded for the signed low 12 bits
    task automatic load_const(input rv_reg_idx_t rd, input rv_word_t value);
        rv_word_t upper;
        upper = value + 32'h800;
        emit(enc_u(upper[31:12], rd, OP_LUI));
        emit(enc_i(value[11:0], rd, 3'b000, rd, OP_IMM));
    endtask

    task automatic build_program;
        rv_word_t    a;
        rv_word_t    b;
        rv_word_t    r;
        rv_reg_idx_t pair_rs1 [5];
        rv_reg_idx_t pair_rs2 [5];
        prog_len = 0;
        a = $random(seed);
        r = $random(seed);
        // Opposite signs so SLT and SLTU disagree
        b = {~a[31], r[30:0]};
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int f3 = 0; f3 < 8; f3++) begin
            emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f3), 5'(5 + f3)));
        end
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd13));
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd14));
        for (int f3 = 0; f3 < 8; f3++) begin
            r = $random(seed);
            if (f3 == 1 || f3 == 5) begin
                r[11:5] = '0;
            end
            emit(enc_i(r[11:0], 5'd1, 3'(f3), 5'(15 + f3), OP_IMM));
        end
        r = $random(seed);
        emit(enc_i({7'h20, r[4:0]}, 5'd1, 3'b101, 5'd23, OP_IMM));
        // Back-to-back dependencies and writes to x0
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd24));
        emit(enc_i(12'd5, 5'd24, 3'b000, 5'd24, OP_IMM));
        emit(enc_r(7'h20, 5'd2, 5'd24, 3'b000, 5'd25));
        emit(enc_r(7'h00, 5'd25, 5'd25, 3'b000, 5'd0));
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd0, OP_IMM));
        emit(enc_i(12'd7, 5'd0, 3'b000, 5'd26, OP_IMM));
        // Branch operands differing only in the high half or only in the low half
        a = $random(seed);
        r = $random(seed);
        load_const(5'd26, a);
        load_const(5'd27, a ^ {r[31:16] | 16'h8000, 16'h0000});
        load_const(5'd28, a ^ {16'h0000, r[15:0] | 16'h8000});
        pair_rs1 = '{5'd26, 5'd27, 5'd26, 5'd28, 5'd26};
        pair_rs2 = '{5'd27, 5'd26, 5'd28, 5'd26, 5'd26};
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 != 2 && f3 != 3) begin
                for (int p = 0; p < 5; p++) begin
                    emit(enc_b(13'd8, pair_rs2[p], pair_rs1[p], 3'(f3)));
                    emit(enc_i(12'd1, 5'd29, 3'b000, 5'd29, OP_IMM));
                end
            end
        end
        r = $random(seed);
        emit(enc_u(r[19:0], 5'd30, OP_AUIPC));
        emit(enc_j(21'd8, 5'd31));
        emit(enc_i(12'd100, 5'd29, 3'b000, 5'd29, OP_IMM));
        emit(enc_u(20'd0, 5'd30, OP_AUIPC));
        // The odd offset loses bit 0 and lands past the skipped word
        emit(enc_i(12'd13, 5'd30, 3'b000, 5'd31, OP_JALR));
        emit(enc_i(12'd100, 5'd29, 3'b000, 5'd29, OP_IMM));
        for (int n = 1; n < 32; n++) begin
            emit(enc_i(12'd0, 5'(n), 3'b000, 5'(n), OP_IMM));
        end
    endtask

    task automatic build_expected;
        rv_word_t    ref_pc;
        exp_t        e;
        rv_reg_idx_t rd;
        logic        we;
        rv_word_t    data;
        logic        taken;
        rv_word_t    target;
        int          steps;
        ref_pc = '0;
        steps  = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        while (ref_pc < 4 * prog_len && steps < 4 * prog_len) begin
            rv_ref_step(prog[ref_pc[9:2]], ref_pc, rd, we, data, taken, target);
            e = '{pc: ref_pc, we: we, rd: rd, data: data, taken: taken, target: target};
            exp_q.push_back(e);
            ref_pc = taken ? target : ref_pc + 32'd4;
            steps++;
        end
    endtask

    task automatic check_wb(input logic exp_we, input rv_reg_idx_t exp_rd,
                            input rv_word_t exp_data, input rv_word_t at_pc);
        checks++;
        if (wb_reg_write !== exp_we) begin
            $display("Error: wb_reg_write expected %h got %h (pc %h)", exp_we, wb_reg_write, at_pc);
            errors++;
        end else if (exp_we && wb_rd !== exp_rd) begin
            $display("Error: wb_rd expected %h got %h (pc %h)", exp_rd, wb_rd, at_pc);
            errors++;
        end else if (exp_we && wb_data !== exp_data) begin
            $display("Error: wb_data expected %h got %h (pc %h)", exp_data, wb_data, at_pc);
            errors++;
        end
    endtask

    task automatic check_redirect(input logic exp_taken, input rv_word_t exp_target,
                                  input rv_word_t at_pc);
        checks++;
        if (redirect !== exp_taken) begin
            $display("Error: redirect expected %h got %h (pc %h)", exp_taken, redirect, at_pc);
            errors++;
        end else if (exp_taken && redirect_pc !== exp_target) begin
            $display("Error: redirect_pc expected %h got %h (pc %h)",
                     exp_target, redirect_pc, at_pc);
            errors++;
        end
    endtask

    task automatic present_instr(input rv_word_t addr);
        if (addr < 4 * prog_len) begin
            instr_valid = 1'b1;
            instr       = prog[addr[9:2]];
            pc          = addr;
        end else begin
            instr_valid = 1'b0;
        end
    endtask

    // Fetch model that follows redirect_pc one slot after the jump
    always @(negedge clk) begin
        if (fetch_on) begin
            if (redirect === 1'b1 && ID_EX_REG != 0) begin
                // Shadow slot that the pipeline flushes
                present_instr(fetch_pc);
                fetch_pc = redirect_pc;
            end else begin
                if (redirect === 1'b1) begin
                    fetch_pc = redirect_pc;
                end
                slot++;
                if (slot % 7 == 5) begin
                    instr_valid = 1'b0;
                end else begin
                    present_instr(fetch_pc);
                    fetch_pc = fetch_pc + 32'd4;
                end
            end
        end
    end

    initial begin
        exp_t e;
        // Registers are unknown before the first reset edge
        @(posedge clk);
        forever begin
            @(posedge clk);
            if (wb_valid !== 1'b1) begin
                if (wb_valid !== 1'b0) begin
                    $display("Error: wb_valid expected 0 got %h", wb_valid);
                    errors++;
                end
                check_wb(1'b0, '0, '0, pc);
                check_redirect(1'b0, '0, pc);
            end else if (quiet) begin
                $display("Error: wb_valid expected 0 got %h during reset or idle", wb_valid);
                errors++;
            end else if (exp_q.size() == 0) begin
                $display("Write-back seen after the last expected instruction");
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_wb(e.we, e.rd, e.data, e.pc);
                check_redirect(e.taken, e.target, e.pc);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, %0d results never seen",
                     cycle_count, exp_q.size());
            $display("Result checks: %0d, errors: %0d", checks, errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        rst_n       = 1'b0;
        // The registered stage must hold back a valid jump during reset
        instr_valid = (ID_EX_REG != 0);
        instr       = enc_j(21'd8, 5'd1);
        pc          = '0;
        quiet       = 1'b1;
        fetch_on    = 1'b0;
        fetch_pc    = '0;
        slot        = 0;
        seed        = 10;
        build_program();
        build_expected();
        cycle_limit = 3 * prog_len + 20;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n       = 1'b1;
        instr_valid = 1'b0;
        // Idle with instr_valid low before the program starts
        repeat (3) @(posedge clk);
        quiet    <= 1'b0;
        fetch_on <= 1'b1;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(posedge clk);
        $display("Result checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core_slice.f
logic/rv_pkg.sv
logic/rv_id_ex_if.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_reg_id_ex.sv
logic/rv_execute.sv
logic/rv_core_slice.sv
tb/rv_core_slice_tb.sv

// File: Bender.yml
package:
  name: rv_core_slice

sources:
  - files:
      - logic/rv_pkg.sv
      - logic/rv_id_ex_if.sv
      - logic/rv_decode.sv
      - logic/rv_regfile.sv
      - logic/rv_reg_id_ex.sv
      - logic/rv_execute.sv
      - logic/rv_core_slice.sv
  - target: simulation
    files:
      - tb/rv_core_slice_tb.sv
